//--- lmem_top.f
+incdir+design
design/lmem_pkg.sv
design/lmem_req_sched.sv
design/lmem_bank.sv
design/lmem_rsp_merge.sv
design/lmem_top.sv
sim/lmem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lmem_tb
FILELIST  = lmem_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/lmem_tb.sv
`include "lmem_params.svh"

module lmem_tb;
    import lmem_pkg::*;

    localparam int NUM_ENTRIES    = 14;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;
    localparam int DRAIN_CYCLES   = 60;

    typedef struct packed {
        lmem_req_t req;
        logic      bp;
    } stim_t;

    typedef struct packed {
        logic [`LMEM_WORD_WIDTH-1:0] data;
        logic [`LMEM_TAG_WIDTH-1:0]  tag;
    } expect_t;

    logic                                           clk;
    logic                                           rst;
    logic                                           req_valid;
    lmem_req_t                                      req;
    logic                                           req_ready;
    logic [`LMEM_NUM_REQS-1:0]                      rsp_valid;
    logic [`LMEM_NUM_REQS-1:0][`LMEM_WORD_WIDTH-1:0] rsp_data;
    logic [`LMEM_NUM_REQS-1:0][`LMEM_TAG_WIDTH-1:0]  rsp_tag;
    logic [`LMEM_NUM_REQS-1:0]                      rsp_ready = '1;

    stim_t                       stim [NUM_ENTRIES];
    int                          n_entries = 0;
    logic [`LMEM_WORD_WIDTH-1:0] model [1 << `LMEM_ADDR_WIDTH];
    expect_t                     exp_q [`LMEM_NUM_REQS][$];

    logic        bp_on     = 1'b0;
    logic [31:0] lcg_state = 32'd84;
    int          cycles    = 0;

    int data_errs       = 0;
    int unexpected_errs = 0;
    int missing_errs    = 0;
    int reset_errs      = 0;

    lmem_top UUT (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_tag   (rsp_tag),
        .rsp_ready (rsp_ready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic print_counts();
        $display("Errors: data %0d, unexpected %0d, missing %0d, reset %0d",
                 data_errs, unexpected_errs, missing_errs, reset_errs);
    endtask

    // Random per-lane back-pressure while the current entry asks for it
    always @(posedge clk) begin
        if (bp_on) begin
            lcg_state = lcg_step(lcg_state);
            rsp_ready <= lcg_state[19:16];
        end else begin
            rsp_ready <= '1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic add_entry(input lmem_op_e op, input logic [3:0] mask,
                             input logic [6:0] a0, input logic [6:0] a1,
                             input logic [6:0] a2, input logic [6:0] a3,
                             input logic [31:0] base, input logic [7:0] tag,
                             input logic bp);
        stim_t s;
        s            = '0;
        s.req.op     = op;
        s.req.mask   = mask;
        s.req.addr[0] = a0;
        s.req.addr[1] = a1;
        s.req.addr[2] = a2;
        s.req.addr[3] = a3;
        for (int l = 0; l < `LMEM_NUM_REQS; l++) begin
            s.req.data[l] = base + 32'h0101_0101 * 32'(l);
        end
        s.req.tag = tag;
        s.bp      = bp;
        stim[n_entries] = s;
        n_entries++;
    endtask

    // Addresses with an even number sit in bank 0, odd ones in bank 1
    task automatic fill_table();
        add_entry(LMEM_OP_WRITE, 4'b1111, 7'd0,  7'd1,  7'd2,  7'd3,  32'hA000_0000, 8'h01, 1'b0);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd0,  7'd1,  7'd2,  7'd3,  32'h0,         8'h02, 1'b0);
        add_entry(LMEM_OP_WRITE, 4'b1111, 7'd10, 7'd12, 7'd14, 7'd16, 32'hB000_0010, 8'h03, 1'b0);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd16, 7'd14, 7'd12, 7'd10, 32'h0,         8'h04, 1'b0);
        add_entry(LMEM_OP_WRITE, 4'b0101, 7'd21, 7'd0,  7'd33, 7'd0,  32'hC000_0020, 8'h05, 1'b0);
        add_entry(LMEM_OP_READ,  4'b1010, 7'd0,  7'd33, 7'd0,  7'd21, 32'h0,         8'h06, 1'b0);
        // An empty mask writes nothing, the later reads of these addresses see the old words
        add_entry(LMEM_OP_WRITE, 4'b0000, 7'd2,  7'd3,  7'd0,  7'd1,  32'hDEAD_0000, 8'h07, 1'b0);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd1,  7'd3,  7'd10, 7'd33, 32'h0,         8'h08, 1'b0);
        add_entry(LMEM_OP_WRITE, 4'b1111, 7'd40, 7'd41, 7'd43, 7'd45, 32'hD000_0040, 8'h09, 1'b1);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd45, 7'd43, 7'd41, 7'd40, 32'h0,         8'h0A, 1'b1);
        add_entry(LMEM_OP_WRITE, 4'b1111, 7'd50, 7'd52, 7'd54, 7'd56, 32'hE000_0050, 8'h0B, 1'b1);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd56, 7'd54, 7'd52, 7'd50, 32'h0,         8'h0C, 1'b1);
        add_entry(LMEM_OP_READ,  4'b1111, 7'd0,  7'd21, 7'd12, 7'd41, 32'h0,         8'h0D, 1'b1);
        add_entry(LMEM_OP_READ,  4'b0011, 7'd2,  7'd3,  7'd0,  7'd0,  32'h0,         8'h0E, 1'b0);
    endtask

    task automatic record_expected(input int i);
        expect_t e;
        for (int l = 0; l < `LMEM_NUM_REQS; l++) begin
            if (stim[i].req.mask[l]) begin
                if (stim[i].req.op == LMEM_OP_WRITE) begin
                    model[stim[i].req.addr[l]] = stim[i].req.data[l];
                end
                e.data = model[stim[i].req.addr[l]];
                e.tag  = stim[i].req.tag;
                exp_q[l].push_back(e);
            end
        end
    endtask

    task automatic send_req(input int i);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= stim[i].req;
        bp_on     <= stim[i].bp;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        record_expected(i);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // Responses of different requests may pass each other, so match on the tag
    task automatic check_rsp(input int lane);
        int pos;
        pos = -1;
        for (int k = 0; k < exp_q[lane].size(); k++) begin
            if (pos < 0 && exp_q[lane][k].tag == rsp_tag[lane]) begin
                pos = k;
            end
        end
        assert (pos >= 0) else begin
            $display("Unexpected response on lane %0d with tag %h", lane, rsp_tag[lane]);
            unexpected_errs++;
        end
        if (pos >= 0) begin
            assert (rsp_data[lane] == exp_q[lane][pos].data) else begin
                $display("** Error: rsp_data[%0d] tag %h got %h expected %h",
                         lane, rsp_tag[lane], rsp_data[lane], exp_q[lane][pos].data);
                data_errs++;
            end
            exp_q[lane].delete(pos);
        end
    endtask

    function automatic logic queues_empty();
        for (int l = 0; l < `LMEM_NUM_REQS; l++) begin
            if (exp_q[l].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    always @(negedge clk) begin
        if (!rst) begin
            for (int l = 0; l < `LMEM_NUM_REQS; l++) begin
                if (rsp_valid[l] && rsp_ready[l]) begin
                    check_rsp(l);
                end
            end
        end
    end

    initial begin
        int drain;
        int total;
        clk       = 1'b0;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        fill_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (rsp_valid == '0) else begin
            $display("** Error: rsp_valid got %h expected %h", rsp_valid, 4'h0);
            reset_errs++;
        end
        assert (req_ready == 1'b1) else begin
            $display("** Error: req_ready got %h expected %h", req_ready, 1'b1);
            reset_errs++;
        end

        for (int i = 0; i < n_entries; i++) begin
            send_req(i);
        end

        bp_on <= 1'b0;
        drain = 0;
        while (!queues_empty() && drain < DRAIN_CYCLES) begin
            @(negedge clk);
            drain++;
        end
        // A few idle cycles to catch stray responses
        repeat (5) @(negedge clk);

        for (int l = 0; l < `LMEM_NUM_REQS; l++) begin
            assert (exp_q[l].size() == 0) else begin
                $display("Missing %0d response(s) on lane %0d", exp_q[l].size(), l);
                missing_errs++;
            end
        end

        total = data_errs + unexpected_errs + missing_errs + reset_errs;
        print_counts();
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- design/lmem_top.sv
`include "lmem_params.svh"

module lmem_top (
    input  logic                                                clk,
    input  logic                                                rst,

    input  logic                                                req_valid,
    input  lmem_pkg::lmem_req_t                                 req,
    output logic                                                req_ready,

    output logic [`LMEM_NUM_REQS-1:0]                           rsp_valid,
    output logic [`LMEM_NUM_REQS-1:0][`LMEM_WORD_WIDTH-1:0]     rsp_data,
    output logic [`LMEM_NUM_REQS-1:0][`LMEM_TAG_WIDTH-1:0]      rsp_tag,
    input  logic [`LMEM_NUM_REQS-1:0]                           rsp_ready
);
    import lmem_pkg::*;

    logic [`LMEM_NUM_BANKS-1:0]         bank_req_valid;
    logic [`LMEM_NUM_BANKS-1:0]         bank_req_ready;
    bank_req_t [`LMEM_NUM_BANKS-1:0]    bank_req;

    logic [`LMEM_NUM_BANKS-1:0]         bank_rsp_valid;
    logic [`LMEM_NUM_BANKS-1:0]         bank_rsp_ready;
    bank_rsp_t [`LMEM_NUM_BANKS-1:0]    bank_rsp;

    lmem_req_sched req_sched (
        .clk            (clk),
        .rst            (rst),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_req       (bank_req),
        .bank_req_ready (bank_req_ready)
    );

    for (genvar b = 0; b < `LMEM_NUM_BANKS; b++) begin : g_bank
        lmem_bank bank (
            .clk        (clk),
            .rst        (rst),
            .req_valid  (bank_req_valid[b]),
            .req        (bank_req[b]),
            .req_ready  (bank_req_ready[b]),
            .rsp_valid  (bank_rsp_valid[b]),
            .rsp        (bank_rsp[b]),
            .rsp_ready  (bank_rsp_ready[b])
        );
    end

    lmem_rsp_merge rsp_merge (
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_ready (bank_rsp_ready),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .rsp_tag        (rsp_tag),
        .rsp_ready      (rsp_ready)
    );

endmodule

//--- design/lmem_rsp_merge.sv
`include "lmem_params.svh"

module lmem_rsp_merge (
    input  logic [`LMEM_NUM_BANKS-1:0]                          bank_rsp_valid,
    input  lmem_pkg::bank_rsp_t [`LMEM_NUM_BANKS-1:0]           bank_rsp,
    output logic [`LMEM_NUM_BANKS-1:0]                          bank_rsp_ready,

    output logic [`LMEM_NUM_REQS-1:0]                           rsp_valid,
    output logic [`LMEM_NUM_REQS-1:0][`LMEM_WORD_WIDTH-1:0]     rsp_data,
    output logic [`LMEM_NUM_REQS-1:0][`LMEM_TAG_WIDTH-1:0]      rsp_tag,
    input  logic [`LMEM_NUM_REQS-1:0]                           rsp_ready
);

    // One-hot per lane with the bit set for the bank that currently drives that lane
    logic [`LMEM_NUM_REQS-1:0][`LMEM_NUM_BANKS-1:0] bank_sel;

    // Walking from the highest bank down lets the lowest valid bank win a lane
    always_comb begin
        rsp_valid = '0;
        rsp_data  = '0;
        rsp_tag   = '0;
        bank_sel  = '0;
        for (int b = `LMEM_NUM_BANKS - 1; b >= 0; b--) begin
            if (bank_rsp_valid[b]) begin
                rsp_valid[bank_rsp[b].idx]   = 1'b1;
                rsp_data[bank_rsp[b].idx]    = bank_rsp[b].data;
                rsp_tag[bank_rsp[b].idx]     = bank_rsp[b].tag;
                bank_sel[bank_rsp[b].idx]    = '0;
                bank_sel[bank_rsp[b].idx][b] = 1'b1;
            end
        end
    end

    // A losing bank keeps its response until its lane is free
    for (genvar b = 0; b < `LMEM_NUM_BANKS; b++) begin : g_ready
        assign bank_rsp_ready[b] = bank_sel[bank_rsp[b].idx][b]
                                && rsp_ready[bank_rsp[b].idx];
    end

endmodule

//--- design/lmem_bank.sv
`include "lmem_params.svh"

module lmem_bank (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    req_valid,
    input  lmem_pkg::bank_req_t     req,
    output logic                    req_ready,

    output logic                    rsp_valid,
    output lmem_pkg::bank_rsp_t     rsp,
    input  logic                    rsp_ready
);
    import lmem_pkg::*;

    logic [`LMEM_WORD_WIDTH-1:0] mem [`LMEM_BANK_DEPTH];

    logic req_fire;
    logic is_write;

    // Accept a new access when the response slot is free or being emptied this cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign req_fire  = req_valid && req_ready;
    assign is_write  = (req.op == LMEM_OP_WRITE);

    always_ff @(posedge clk) begin
        if (req_fire && is_write) begin
            mem[req.offset] <= req.data;
        end
    end

    // A write echoes its own data, a read returns the old contents
    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (is_write) begin
                rsp.data <= req.data;
            end else begin
                rsp.data <= mem[req.offset];
            end
            rsp.idx <= req.idx;
            rsp.tag <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

endmodule

//--- design/lmem_req_sched.sv
`include "lmem_params.svh"

module lmem_req_sched (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        req_valid,
    input  lmem_pkg::lmem_req_t                         req,
    output logic                                        req_ready,

    output logic [`LMEM_NUM_BANKS-1:0]                  bank_req_valid,
    output lmem_pkg::bank_req_t [`LMEM_NUM_BANKS-1:0]   bank_req,
    input  logic [`LMEM_NUM_BANKS-1:0]                  bank_req_ready
);
    import lmem_pkg::*;

    sched_state_e state;

    // Held copy of the accepted request
    lmem_req_t req_r;

    // Lanes of the held request that still wait for their bank access
    logic [`LMEM_NUM_REQS-1:0] pending;
    logic [`LMEM_NUM_REQS-1:0] served;
    logic [`LMEM_NUM_REQS-1:0] pending_next;

    logic [`LMEM_NUM_BANKS-1:0]                         sel_found;
    logic [`LMEM_NUM_BANKS-1:0][`LMEM_LANE_BITS-1:0]    sel_lane;

    assign req_ready = (state == SCHED_IDLE);

    // Pick the lowest pending lane per bank, scanning down so the lowest one wins
    always_comb begin
        sel_found = '0;
        sel_lane  = '0;
        for (int b = 0; b < `LMEM_NUM_BANKS; b++) begin
            for (int r = `LMEM_NUM_REQS - 1; r >= 0; r--) begin
                if (pending[r] && (int'(req_r.addr[r][`LMEM_BANK_SEL_BITS-1:0]) == b)) begin
                    sel_found[b] = 1'b1;
                    sel_lane[b]  = r[`LMEM_LANE_BITS-1:0];
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < `LMEM_NUM_BANKS; b++) begin
            bank_req_valid[b]  = (state == SCHED_SERVE) && sel_found[b];
            bank_req[b].op     = req_r.op;
            bank_req[b].offset = req_r.addr[sel_lane[b]][`LMEM_ADDR_WIDTH-1:`LMEM_BANK_SEL_BITS];
            bank_req[b].data   = req_r.data[sel_lane[b]];
            bank_req[b].idx    = sel_lane[b];
            bank_req[b].tag    = req_r.tag;
        end
    end

    // Each bank serves at most one lane per cycle, so the served bits never collide
    always_comb begin
        served = '0;
        for (int b = 0; b < `LMEM_NUM_BANKS; b++) begin
            if (bank_req_valid[b] && bank_req_ready[b]) begin
                served[sel_lane[b]] = 1'b1;
            end
        end
    end

    assign pending_next = pending & ~served;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SCHED_IDLE;
            pending <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    if (req_valid) begin
                        pending <= req.mask;
                        // An empty mask has nothing to serve and leaves the FSM idle
                        if (|req.mask) begin
                            state <= SCHED_SERVE;
                        end
                    end
                end
                SCHED_SERVE: begin
                    pending <= pending_next;
                    if (pending_next == '0) begin
                        state <= SCHED_IDLE;
                    end
                end
                default: begin
                    state <= SCHED_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_r <= req;
        end
    end

endmodule

//--- design/lmem_pkg.sv
`include "lmem_params.svh"

package lmem_pkg;

    typedef enum logic {
        LMEM_OP_READ  = 1'b0,
        LMEM_OP_WRITE = 1'b1
    } lmem_op_e;

    typedef enum logic {
        SCHED_IDLE  = 1'b0,
        SCHED_SERVE = 1'b1
    } sched_state_e;

    // One core request with a single op and tag shared by all lanes
    typedef struct packed {
        lmem_op_e                                           op;
        logic [`LMEM_NUM_REQS-1:0]                          mask;
        logic [`LMEM_NUM_REQS-1:0][`LMEM_ADDR_WIDTH-1:0]    addr;
        logic [`LMEM_NUM_REQS-1:0][`LMEM_WORD_WIDTH-1:0]    data;
        logic [`LMEM_TAG_WIDTH-1:0]                         tag;
    } lmem_req_t;

    // One access to a single bank on behalf of one lane
    typedef struct packed {
        lmem_op_e                       op;
        logic [`LMEM_OFFSET_WIDTH-1:0]  offset;
        logic [`LMEM_WORD_WIDTH-1:0]    data;
        logic [`LMEM_LANE_BITS-1:0]     idx;
        logic [`LMEM_TAG_WIDTH-1:0]     tag;
    } bank_req_t;

    // The lane index travels with the data so the merge can route it back
    typedef struct packed {
        logic [`LMEM_WORD_WIDTH-1:0]    data;
        logic [`LMEM_LANE_BITS-1:0]     idx;
        logic [`LMEM_TAG_WIDTH-1:0]     tag;
    } bank_rsp_t;

endpackage

//--- design/lmem_params.svh
`ifndef LMEM_PARAMS_SVH
`define LMEM_PARAMS_SVH

// Lanes per core request
`define LMEM_NUM_REQS       4

// Bank count must stay a power of two because the bank is taken from the low address bits
`define LMEM_NUM_BANKS      2

`define LMEM_WORD_WIDTH     32
`define LMEM_TAG_WIDTH      8
`define LMEM_BANK_DEPTH     64
`define LMEM_ADDR_WIDTH     7

// Derived widths
`define LMEM_BANK_SEL_BITS  ($clog2(`LMEM_NUM_BANKS))
`define LMEM_OFFSET_WIDTH   (`LMEM_ADDR_WIDTH - `LMEM_BANK_SEL_BITS)
`define LMEM_LANE_BITS      ($clog2(`LMEM_NUM_REQS))

`endif
